// File: Makefile
TOP := cpuTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f list.f

obj_dir/V$(TOP): list.f verilog/*.sv tb/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f list.f

sim: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf obj_dir

// File: list.f
verilog/cpuPkg.sv
verilog/regFile.sv
verilog/alu.sv
verilog/fetchUnit.sv
verilog/dataMem.sv
verilog/controlDecoder.sv
verilog/cpuTop.sv
tb/cpuTb.sv

// File: tb/cpuTb.sv
// testbench with LFSR program generation, ISA reference model and commit and pc checks
`timescale 1ns/10ps

module cpuTb;
  import cpuPkg::*;

  localparam int progLen     = 48;  // random words ahead of the halt
  localparam int loadLen     = 64;
  localparam int numProgs    = 8;
  localparam int resetCycles = 16;
  localparam int timeoutCycles =
    numProgs * (progLen + loadLen + 20 + resetCycles) + resetCycles;
  localparam instrT haltWord = 9'b111_11_0000;

  logic     clk;
  logic     arstN;
  logic     progWe;
  logic     start;
  logic     running;
  logic     done;
  pcT       progAddr;
  pcT       pc;
  instrT    progData;
  regWriteT regCommit;
  memWriteT memCommit;

  logic [31:0] lfsr = 32'hb44080c9;
  instrT       prog [loadLen];
  regWriteT    expRegQ [$];  // one entry per executed instruction
  memWriteT    expMemQ [$];
  pcT          expPcQ [$];
  int          cycles = 0;

  cpuTop #(.aluOpWidth(4)) i_cpuTop (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [8:0] randBits(input int n);
    logic [8:0] v;
    logic       fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // x^32+x^22+x^2+x+1
      lfsr = {lfsr[30:0], fb};
      v    = {v[7:0], fb};
    end
    return v;
  endfunction

  task automatic stopRun();
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic checkEq(input string name, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp) else begin
      $display("FAIL at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      stopRun();
    end
  endtask

  task automatic checkTrue(input logic cond, input string what);
    assert (cond) else begin
      $display("%s", what);
      stopRun();
    end
  endtask

  task automatic buildProgram();
    instrT ins;
    int    maxOff;
    for (int i = 0; i < progLen; i++) begin
      ins = instrT'(randBits(9));
      if (ins[8:6] == 3'd7 && ins[5:4] == 2'd3) ins[5:4] = 2'd2;  // halt only at the end
      if (ins[8:6] == 3'd4) begin
        maxOff = progLen - 1 - i;  // target may land on the halt at most
        if (int'(ins[3:0]) > maxOff) ins[3:0] = maxOff[3:0];
      end
      prog[i] = ins;
    end
    for (int i = progLen; i < loadLen; i++) prog[i] = haltWord;
  endtask

  task automatic runModel();
    byteT        r [16];
    byteT        m [256];
    pcT          p;
    instrT       ins;
    byteT        a, b, val, stAddr, stData, lutAddr;
    regAddrT     dst;
    logic        doWr, doSt, halted, taken;
    logic [15:0] wide;
    r = '{default: '0};
    m = '{default: '0};
    p = '0;
    halted = 1'b0;
    expRegQ.delete();
    expMemQ.delete();
    expPcQ.delete();
    while (!halted) begin
      ins     = prog[p];
      a       = r[0];
      b       = r[1];
      lutAddr = byteT'(ins[5:1] * 7 + 5);  // table entry i*7+5
      dst     = ins[3:0];
      val     = '0;
      stAddr  = a;
      stData  = '0;
      doWr    = 1'b1;
      doSt    = 1'b0;
      taken   = 1'b0;
      case (ins[8:6])
        3'd0: begin
          case (ins[5:4])
            2'd0: val = a + b;
            2'd1: val = a - b;
            2'd2: val = m[a];
            default: begin
              doWr   = 1'b0;
              doSt   = 1'b1;
              stData = r[ins[3:0]];
            end
          endcase
        end
        3'd1: begin  // lb
          dst = {3'b0, ins[0]};
          val = m[lutAddr];
        end
        3'd2: begin  // sb
          doWr   = 1'b0;
          doSt   = 1'b1;
          stAddr = lutAddr;
          stData = r[ins[0]];
        end
        3'd3: begin
          dst = 4'd1;
          val = a + byteT'(ins[5:1]);
        end
        3'd4: begin
          doWr = 1'b0;
          case (ins[5:4])
            2'd0:    taken = (a == b);
            2'd1:    taken = (a != b);
            2'd2:    taken = (a < b);
            default: taken = (a <= b);
          endcase
        end
        3'd5: begin  // move in two forms
          dst = ins[5] ? ins[4:1] : {3'b0, ins[4]};
          val = ins[5] ? r[ins[0]] : r[ins[3:0]];
        end
        3'd6: begin
          wide = {{8{a[7]}}, a} >> b[2:0];  // sign filled
          case (ins[5:4])
            2'd0:    val = a << b[2:0];
            2'd1:    val = wide[7:0];
            2'd2:    val = a >> b[2:0];
            default: val = ~a;
          endcase
        end
        default: begin
          wide = 16'(a) * 16'(b);
          case (ins[5:4])
            2'd0: val = a & b;
            2'd1: val = a | b;
            2'd2: val = wide[7:0];
            default: begin
              doWr   = 1'b0;
              halted = 1'b1;
            end
          endcase
        end
      endcase
      expPcQ.push_back(p);
      expRegQ.push_back('{en: doWr, addr: dst, data: val});
      expMemQ.push_back('{en: doSt, addr: stAddr, data: stData});
      if (doWr) r[dst] = val;
      if (doSt) m[stAddr] = stData;
      p = taken ? p + pcT'(ins[3:0]) + 8'd1 : p + 8'd1;
    end
  endtask

  task automatic applyReset();
    arstN = 1'b0;
    repeat (resetCycles) @(negedge clk);
    arstN = 1'b1;
    @(negedge clk);
  endtask

  task automatic checkIdle();
    checkEq("running", 16'(running), 0);
    checkEq("done", 16'(done), 0);
    checkEq("regCommit.en", 16'(regCommit.en), 0);
    checkEq("memCommit.en", 16'(memCommit.en), 0);
    checkEq("pc", 16'(pc), 0);
  endtask

  task automatic runProgram();
    regWriteT expReg;
    memWriteT expMem;
    applyReset();
    checkIdle();
    for (int i = 0; i < loadLen; i++) begin
      progWe   = 1'b1;
      progAddr = pcT'(i);
      progData = prog[i];
      @(negedge clk);
    end
    progWe = 1'b0;
    start  = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (!done) begin  // one instruction per cycle
      checkTrue(running, "CPU is neither running nor done after start");
      checkTrue(expPcQ.size() != 0, "CPU still running after the model reached halt");
      checkEq("pc", 16'(pc), 16'(expPcQ.pop_front()));
      expReg = expRegQ.pop_front();
      expMem = expMemQ.pop_front();
      checkEq("regCommit.en", 16'(regCommit.en), 16'(expReg.en));
      checkEq("memCommit.en", 16'(memCommit.en), 16'(expMem.en));
      if (expReg.en) begin
        checkEq("regCommit.addr", 16'(regCommit.addr), 16'(expReg.addr));
        checkEq("regCommit.data", 16'(regCommit.data), 16'(expReg.data));
      end
      if (expMem.en) begin
        checkEq("memCommit.addr", 16'(memCommit.addr), 16'(expMem.addr));
        checkEq("memCommit.data", 16'(memCommit.data), 16'(expMem.data));
      end
      @(negedge clk);
    end
    checkTrue(expPcQ.size() == 0, "done rose before the model reached halt");
    checkTrue(expRegQ.size() == 0, "register writes left over in the model queue");
    checkTrue(expMemQ.size() == 0, "stores left over in the model queue");
    repeat (4) begin  // done holds until the next start
      checkEq("done", 16'(done), 1);
      checkEq("running", 16'(running), 0);
      @(negedge clk);
    end
  endtask

  initial begin
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > timeoutCycles) begin
        $display("timeout: tests did not finish within %0d cycles", timeoutCycles);
        stopRun();
      end
    end
  end

  initial begin
    arstN    = 1'b0;
    progWe   = 1'b0;
    progAddr = '0;
    progData = '0;
    start    = 1'b0;
    for (int p = 0; p < numProgs; p++) begin
      buildProgram();
      runModel();
      runProgram();
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: verilog/alu.sv
// 8-bit ALU: add, sub, shifts, not, and, or, mul low byte, pass
`timescale 1ns/10ps

module alu #(
  parameter int aluOpWidth = 4
) (
  input  cpuPkg::byteT  a,
  input  cpuPkg::byteT  b,
  input  cpuPkg::aluOpT op,
  output cpuPkg::byteT  rslt
);
  import cpuPkg::*;

  logic [aluOpWidth-1:0] opCode;  // op field at configured width
  logic [2:0]            shAmt;
  logic [15:0]           product;

  assign opCode  = aluOpWidth'(op);
  assign shAmt   = b[2:0];  // low 3 bits only
  assign product = {8'b0, a} * {8'b0, b};

  always_comb begin
    case (opCode)
      aluOpWidth'(opAdd): rslt = a + b;
      aluOpWidth'(opSub): rslt = a - b;
      aluOpWidth'(opLsl): rslt = a << shAmt;
      aluOpWidth'(opAsr): rslt = byteT'($signed(a) >>> shAmt);
      aluOpWidth'(opLsr): rslt = a >> shAmt;
      aluOpWidth'(opNot): rslt = ~a;
      aluOpWidth'(opAnd): rslt = a & b;
      aluOpWidth'(opOr):  rslt = a | b;
      aluOpWidth'(opMul): rslt = product[7:0];  // keep low byte
      default:            rslt = a;             // pass, also undefined codes
    endcase
  end

endmodule

// File: verilog/controlDecoder.sv
// combinational instruction decoder with write-back/store steering and branch decision
`timescale 1ns/10ps

module controlDecoder (
  input  logic              running,
  input  cpuPkg::instrT     instr,
  input  cpuPkg::byteT      datA,
  input  cpuPkg::byteT      datB,
  input  cpuPkg::byteT      memOut,
  input  cpuPkg::byteT      lutOut,
  input  cpuPkg::byteT      aluRslt,
  output cpuPkg::regAddrT   regA,
  output cpuPkg::regAddrT   regB,
  output cpuPkg::aluOpT     aluOp,
  output logic              aluSrc,
  output cpuPkg::immT       immed,
  output cpuPkg::immT       lutIdx,
  output cpuPkg::regWriteT  regWrite,
  output cpuPkg::memWriteT  memWrite,
  output cpuPkg::byteT      memAddr,
  output logic              branch,
  output logic [3:0]        pcImmed,
  output logic              halt
);
  import cpuPkg::*;

  logic [2:0] opcode;
  logic [1:0] funct;
  logic       wrEn;   // register write before run gating
  logic       memWe;  // store before run gating
  regAddrT    wrAddr;
  byteT       datIn;
  byteT       memIn;

  assign opcode = instr[8:6];
  assign funct  = instr[5:4];
  assign immed  = instr[5:1];
  assign lutIdx = instr[5:1];

  always_comb begin
    regA    = 4'd0;
    regB    = 4'd1;
    aluOp   = opPass;
    aluSrc  = 1'b0;
    wrEn    = 1'b1;  // most instructions write back
    memWe   = 1'b0;
    wrAddr  = instr[3:0];
    datIn   = aluRslt;
    memIn   = datB;
    memAddr = datA;
    branch  = 1'b0;
    pcImmed = 4'd0;
    halt    = 1'b0;
    case (opcode)
      3'b000: begin
        case (funct)
          2'b00: aluOp = opAdd;
          2'b01: aluOp = opSub;
          2'b10: datIn = memOut;  // load from mem[R0]
          default: begin          // store to mem[R0]
            regB  = instr[3:0];
            wrEn  = 1'b0;
            memWe = 1'b1;
          end
        endcase
      end
      3'b001: begin  // lb
        memAddr = lutOut;
        datIn   = memOut;
        wrAddr  = {3'b0, instr[0]};
      end
      3'b010: begin  // sb
        regA    = {3'b0, instr[0]};
        memAddr = lutOut;
        memIn   = datA;
        wrEn    = 1'b0;
        memWe   = 1'b1;
      end
      3'b011: begin  // addi into R1
        aluOp  = opAdd;
        aluSrc = 1'b1;
        wrAddr = 4'd1;
      end
      3'b100: begin  // unsigned compares with a forward target
        wrEn    = 1'b0;
        pcImmed = instr[3:0];
        case (funct)
          2'b00:   branch = (datA == datB);
          2'b01:   branch = (datA != datB);
          2'b10:   branch = (datA < datB);
          default: branch = (datA <= datB);
        endcase
      end
      3'b101: begin  // move
        if (!instr[5]) begin
          regA   = instr[3:0];
          wrAddr = {3'b0, instr[4]};
        end else begin
          regA   = {3'b0, instr[0]};
          wrAddr = instr[4:1];
        end
        datIn = datA;
      end
      3'b110: begin
        case (funct)
          2'b00:   aluOp = opLsl;
          2'b01:   aluOp = opAsr;
          2'b10:   aluOp = opLsr;
          default: aluOp = opNot;
        endcase
      end
      default: begin
        case (funct)
          2'b00: aluOp = opAnd;
          2'b01: aluOp = opOr;
          2'b10: aluOp = opMul;
          default: begin  // halt commits nothing
            wrEn = 1'b0;
            halt = 1'b1;
          end
        endcase
      end
    endcase
  end

  assign regWrite = '{en: running & wrEn, addr: wrAddr, data: datIn};
  assign memWrite = '{en: running & memWe, addr: memAddr, data: memIn};

endmodule

// File: verilog/cpuPkg.sv
// shared widths, vector types, ALU op enum, commit structs and address lookup table
package cpuPkg;

  localparam int instrWidth = 9; // fixed by the encoding
  localparam int lutDepth   = 32;

  typedef logic [instrWidth-1:0] instrT;
  typedef logic [7:0]            byteT;    // register and memory data
  typedef logic [3:0]            regAddrT;
  typedef logic [7:0]            pcT;
  typedef logic [4:0]            immT;     // lut index or addi immediate

  typedef enum logic [3:0] {
    opAdd  = 4'd0,
    opSub  = 4'd1,
    opLsl  = 4'd2,
    opAsr  = 4'd3,
    opLsr  = 4'd4,
    opNot  = 4'd5,
    opAnd  = 4'd6,
    opOr   = 4'd7,
    opMul  = 4'd8,  // low byte only
    opPass = 4'd15
  } aluOpT;

  typedef struct packed {
    logic    en;
    regAddrT addr;
    byteT    data;
  } regWriteT;

  typedef struct packed {
    logic en;
    byteT addr;
    byteT data;
  } memWriteT;

  // entry i = 7*i + 5
  localparam byteT addrLut [lutDepth] = '{
    8'd5,   8'd12,  8'd19,  8'd26,  8'd33,  8'd40,  8'd47,  8'd54,
    8'd61,  8'd68,  8'd75,  8'd82,  8'd89,  8'd96,  8'd103, 8'd110,
    8'd117, 8'd124, 8'd131, 8'd138, 8'd145, 8'd152, 8'd159, 8'd166,
    8'd173, 8'd180, 8'd187, 8'd194, 8'd201, 8'd208, 8'd215, 8'd222
  };

endpackage

// File: verilog/cpuTop.sv
// CPU top level: fetch, decode, register file, ALU, data memory and commit trace
`timescale 1ns/10ps

module cpuTop #(
  parameter int aluOpWidth = 4
) (
  input  logic             clk,
  input  logic             arstN,
  input  logic             progWe,
  input  cpuPkg::pcT       progAddr,
  input  cpuPkg::instrT    progData,
  input  logic             start,
  output cpuPkg::regWriteT regCommit,
  output cpuPkg::memWriteT memCommit,
  output cpuPkg::pcT       pc,
  output logic             running,
  output logic             done
);
  import cpuPkg::*;

  instrT      instr;
  regAddrT    regA, regB;
  byteT       datA, datB;
  byteT       aluB, aluRslt;
  byteT       memAddr, memOut, lutOut;
  aluOpT      aluOp;
  logic       aluSrc;
  immT        immed, lutIdx;
  logic       branch, halt;
  logic [3:0] pcImmed;

  fetchUnit i_fetchUnit (
    .clk, .arstN, .progWe, .progAddr, .progData, .start,
    .branch, .pcImmed, .halt,
    .instr, .pc, .running, .done
  );

  controlDecoder i_controlDecoder (
    .running, .instr, .datA, .datB, .memOut, .lutOut, .aluRslt,
    .regA, .regB, .aluOp, .aluSrc, .immed, .lutIdx,
    .regWrite(regCommit), .memWrite(memCommit), .memAddr,
    .branch, .pcImmed, .halt
  );

  regFile i_regFile (
    .clk, .arstN, .rdA(regA), .rdB(regB), .wr(regCommit), .datA, .datB
  );

  assign aluB = aluSrc ? {3'b0, immed} : datB;  // addi immediate

  alu #(.aluOpWidth(aluOpWidth)) i_alu (
    .a(datA), .b(aluB), .op(aluOp), .rslt(aluRslt)
  );

  dataMem i_dataMem (
    .clk, .arstN, .addr(memAddr), .wr(memCommit), .lutIdx,
    .rdData(memOut), .lutOut
  );

endmodule

// File: verilog/dataMem.sv
// 256-byte data memory with the lb/sb address lookup table
`timescale 1ns/10ps

module dataMem (
  input  logic             clk,
  input  logic             arstN,
  input  cpuPkg::byteT     addr,
  input  cpuPkg::memWriteT wr,
  input  cpuPkg::immT      lutIdx,
  output cpuPkg::byteT     rdData,
  output cpuPkg::byteT     lutOut
);
  import cpuPkg::*;

  byteT mem [256];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 256; i++) begin
        mem[i] <= '0;  // each program starts from a clean image
      end
    end else if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  assign rdData = mem[addr];
  assign lutOut = addrLut[lutIdx];  // constant table lookup

  // an X here would corrupt arbitrary memory
  assert property (@(posedge clk) disable iff (!arstN) !$isunknown(wr.en))
    else $error("store enable unknown");

endmodule

// File: verilog/fetchUnit.sv
// instruction store with load port, program counter and run/done control
`timescale 1ns/10ps

module fetchUnit (
  input  logic          clk,
  input  logic          arstN,
  input  logic          progWe,
  input  cpuPkg::pcT    progAddr,
  input  cpuPkg::instrT progData,
  input  logic          start,
  input  logic          branch,
  input  logic [3:0]    pcImmed,
  input  logic          halt,
  output cpuPkg::instrT instr,
  output cpuPkg::pcT    pc,
  output logic          running,
  output logic          done
);
  import cpuPkg::*;

  instrT imem [256];

  always_ff @(posedge clk) begin
    if (progWe && !running) imem[progAddr] <= progData;  // host load
  end

  assign instr = imem[pc];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc      <= '0;
      running <= 1'b0;
      done    <= 1'b0;
    end else if (!running) begin
      if (start) begin
        pc      <= '0;
        running <= 1'b1;
        done    <= 1'b0;
      end
    end else if (halt) begin
      running <= 1'b0;  // pc parks on the halt
      done    <= 1'b1;
    end else begin
      pc <= branch ? pc + {4'b0, pcImmed} + 8'd1 : pc + 8'd1;  // forward only
    end
  end

  assert property (@(posedge clk) disable iff (!arstN) !(progWe && running))
    else $error("program write while running");

endmodule

// File: verilog/regFile.sv
// 16x8 register file, two asynchronous reads and one synchronous write
`timescale 1ns/10ps

module regFile (
  input  logic             clk,
  input  logic             arstN,
  input  cpuPkg::regAddrT  rdA,
  input  cpuPkg::regAddrT  rdB,
  input  cpuPkg::regWriteT wr,
  output cpuPkg::byteT     datA,
  output cpuPkg::byteT     datB
);
  import cpuPkg::*;

  byteT regs [16];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.en) begin
      regs[wr.addr] <= wr.data;
    end
  end

  assign datA = regs[rdA]; // combinational read
  assign datB = regs[rdB];

endmodule
